// File: biquad.f
biquad_arith_pkg.sv
coef_map_pkg.sv
coef_regs.sv
biquad_mac.sv
out_saturate.sv
biquad_top.sv
tb_biquad.sv

// File: biquad_arith_pkg.sv
// arithmetic widths for the biquad datapath
// the top level sets DATA_W, COEF_W and GUARD_W and passes them down,
// these defaults only seed the top level parameters
package biquad_arith_pkg;

	// default sample width of x and y at the ports
	localparam int DATA_W_DEF = 12;

	// default coefficient width, taken from the top of a 16-bit register
	// must be 16 or less
	localparam int COEF_W_DEF = 12;

	// default fraction guard bits below the sample lsb in the accumulator
	// must not exceed COEF_W - 2
	localparam int GUARD_W_DEF = 2;

	// headroom of the feedback state above the output width
	localparam int STATE_EXT = 4;

	// width of the wide y kept for feedback
	function automatic int state_width(input int data_w);
		return data_w + STATE_EXT;
	endfunction

	// width of the partial sums and the y accumulator
	// the state width plus the guard fraction bits
	function automatic int acc_width(input int data_w, input int guard_w);
		return state_width(data_w) + guard_w;
	endfunction

endpackage

// File: biquad_mac.sv
`timescale 1ns/1ps

// biquad multiply-accumulate in transposed direct form II
// y[n] = b10*x[n] + s1
// s1  <= b11*x[n] + a11*y[n] + s2
// s2  <= b12*x[n] + a12*y[n]
// y[n] is combinational so the whole sample finishes in one clock
module biquad_mac
	import biquad_arith_pkg::*;
	import coef_map_pkg::*;
#(
	parameter int DATA_W  = DATA_W_DEF,
	parameter int COEF_W  = COEF_W_DEF,
	parameter int GUARD_W = GUARD_W_DEF
)
(
	input  logic                               clk,
	input  logic                               rst_i,
	input  logic signed [DATA_W-1:0]           x_i,
	input  logic                               valid_i,
	input  coef_set_t                          coefs_i,
	output logic signed [DATA_W+STATE_EXT-1:0] y_full_o,
	output logic                               y_step_o
);

	// wide y for feedback
	localparam int STATE_W = state_width(DATA_W);
	// partial sums carry guard fraction bits below the y lsb
	localparam int ACC_W = acc_width(DATA_W, GUARD_W);
	// product scaling, drops the coefficient fraction except the guard bits
	localparam int SHIFT = COEF_W - 1 - GUARD_W;
	// msb of a coefficient register word
	localparam int COEF_MSB = $bits(wb_word_t) - 1;

	// coefficients cut to their top COEF_W bits
	logic signed [COEF_W-1:0] c_a11;
	logic signed [COEF_W-1:0] c_a12;
	logic signed [COEF_W-1:0] c_b10;
	logic signed [COEF_W-1:0] c_b11;
	logic signed [COEF_W-1:0] c_b12;

	// input sample sign extended to state width
	logic signed [STATE_W-1:0] x_ext;

	// scaled products at accumulator precision
	logic signed [ACC_W-1:0] p_b10;
	logic signed [ACC_W-1:0] p_b11;
	logic signed [ACC_W-1:0] p_b12;
	logic signed [ACC_W-1:0] p_a11;
	logic signed [ACC_W-1:0] p_a12;

	// y accumulator and next partial sums
	logic signed [ACC_W-1:0] acc_y;
	logic signed [ACC_W-1:0] s1_next;
	logic signed [ACC_W-1:0] s2_next;

	// partial sum state
	logic signed [ACC_W-1:0] s1_q;
	logic signed [ACC_W-1:0] s2_q;

	// current output at state width
	logic signed [STATE_W-1:0] y_cur;

	// full precision product, floored to the guard precision
	// the top bit of the shifted product is dropped, sums wrap at ACC_W anyway
	function automatic logic signed [ACC_W-1:0] scale_prod(
		input logic signed [STATE_W-1:0] v,
		input logic signed [COEF_W-1:0]  c
	);
		logic signed [STATE_W+COEF_W-1:0] full;
		logic signed [STATE_W+COEF_W-1:0] shifted;
		full = v * c;
		shifted = full >>> SHIFT;
		return shifted[ACC_W-1:0];
	endfunction

	// fractional two's complement, msbs of each register
	assign c_a11 = coefs_i.a11[COEF_MSB -: COEF_W];
	assign c_a12 = coefs_i.a12[COEF_MSB -: COEF_W];
	assign c_b10 = coefs_i.b10[COEF_MSB -: COEF_W];
	assign c_b11 = coefs_i.b11[COEF_MSB -: COEF_W];
	assign c_b12 = coefs_i.b12[COEF_MSB -: COEF_W];

	assign x_ext = x_i;

	// feedforward products from the current sample
	assign p_b10 = scale_prod(x_ext, c_b10);
	assign p_b11 = scale_prod(x_ext, c_b11);
	assign p_b12 = scale_prod(x_ext, c_b12);

	// output of this sample
	// dropping the guard bits is an arithmetic shift, so it floors
	assign acc_y = p_b10 + s1_q;
	assign y_cur = acc_y[ACC_W-1:GUARD_W];

	// feedback products use this sample's y
	assign p_a11 = scale_prod(y_cur, c_a11);
	assign p_a12 = scale_prod(y_cur, c_a12);

	// next state
	assign s1_next = p_b11 + p_a11 + s2_q;
	assign s2_next = p_b12 + p_a12;

	// state moves only on a valid sample, gaps hold it
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			s1_q <= '0;
			s2_q <= '0;
		end
		else if (valid_i)
		begin
			s1_q <= s1_next;
			s2_q <= s2_next;
		end
	end

	assign y_full_o = y_cur;
	// tells the output stage this y belongs to a real sample
	assign y_step_o = valid_i;

endmodule

// File: biquad_top.sv
`timescale 1ns/1ps

// biquad iir section with its coefficients on a wishbone slave
// one sample per valid_i, output one clock later
module biquad_top
	import biquad_arith_pkg::*;
	import coef_map_pkg::*;
#(
	parameter int DATA_W  = DATA_W_DEF,
	parameter int COEF_W  = COEF_W_DEF,
	parameter int GUARD_W = GUARD_W_DEF
)
(
	input  logic                     clk,
	input  logic                     rst_i,
	// wishbone slave
	input  logic                     cyc_i,
	input  logic                     stb_i,
	input  logic                     we_i,
	input  wb_addr_t                 adr_i,
	input  wb_word_t                 dat_i,
	output logic                     ack_o,
	output wb_word_t                 dat_o,
	// sample stream
	input  logic signed [DATA_W-1:0] x_i,
	input  logic                     valid_i,
	output logic signed [DATA_W-1:0] y_o,
	output logic                     y_valid_o
);

	// coefficient set from the register block
	coef_set_t coefs;
	// wide y and its sample strobe
	logic signed [DATA_W+STATE_EXT-1:0] y_full;
	logic y_step;

	coef_regs u_coef_regs (
		.clk     (clk),
		.rst_i   (rst_i),
		.cyc_i   (cyc_i),
		.stb_i   (stb_i),
		.we_i    (we_i),
		.adr_i   (adr_i),
		.dat_i   (dat_i),
		.ack_o   (ack_o),
		.dat_o   (dat_o),
		.coefs_o (coefs)
	);

	biquad_mac #(
		.DATA_W  (DATA_W),
		.COEF_W  (COEF_W),
		.GUARD_W (GUARD_W)
	) u_biquad_mac (
		.clk      (clk),
		.rst_i    (rst_i),
		.x_i      (x_i),
		.valid_i  (valid_i),
		.coefs_i  (coefs),
		.y_full_o (y_full),
		.y_step_o (y_step)
	);

	out_saturate #(
		.DATA_W (DATA_W)
	) u_out_saturate (
		.clk       (clk),
		.rst_i     (rst_i),
		.y_full_i  (y_full),
		.y_step_i  (y_step),
		.y_o       (y_o),
		.y_valid_o (y_valid_o)
	);

endmodule

// File: coef_map_pkg.sv
// register map of the coefficient block on the wishbone bus
// 16-bit data port, one word per coefficient
package coef_map_pkg;

	// wishbone data port width
	localparam int WB_DW = 16;

	// number of coefficient registers
	localparam int NUM_COEF = 5;

	// word address width, enough to reach every register
	localparam int WB_AW = $clog2(NUM_COEF);

	// bus data word
	typedef logic [WB_DW-1:0] wb_word_t;

	// bus word address
	typedef logic [WB_AW-1:0] wb_addr_t;

	// register addresses, feedback pair first then the feedforward taps
	localparam wb_addr_t ADDR_A11 = 3'd0;
	localparam wb_addr_t ADDR_A12 = 3'd1;
	localparam wb_addr_t ADDR_B10 = 3'd2;
	localparam wb_addr_t ADDR_B11 = 3'd3;
	localparam wb_addr_t ADDR_B12 = 3'd4;

	// full coefficient set as held in the registers
	// each field is the raw 16-bit fractional word,
	// the datapath keeps only its top COEF_W bits
	typedef struct packed {
		wb_word_t a11;
		wb_word_t a12;
		wb_word_t b10;
		wb_word_t b11;
		wb_word_t b12;
	} coef_set_t;

endpackage

// File: coef_regs.sv
`timescale 1ns/1ps

// wishbone classic slave with the five filter coefficient registers
// single read and write cycles only, ack one clock after the request
module coef_regs
	import coef_map_pkg::*;
(
	input  logic      clk,
	input  logic      rst_i,
	input  logic      cyc_i,
	input  logic      stb_i,
	input  logic      we_i,
	input  wb_addr_t  adr_i,
	input  wb_word_t  dat_i,
	output logic      ack_o,
	output wb_word_t  dat_o,
	output coef_set_t coefs_o
);

	// request pending on the bus, not yet acked
	logic req;
	// write strobe for the addressed register
	logic wr_en;
	// read strobe, captures the read word into dat_o
	logic rd_en;
	// registered ack
	logic ack_q;
	// read mux output
	wb_word_t rd_word;
	// coefficient storage
	coef_set_t coef_q;

	// a request is live while cyc and stb are up and we have not acked yet
	// this keeps ack to a single cycle even if the master is slow to drop stb
	assign req = cyc_i & stb_i & ~ack_q;
	assign wr_en = req & we_i;
	assign rd_en = req & ~we_i;

	// read mux
	// unmapped addresses 5 to 7 return zero
	always_comb
	begin
		case (adr_i)
			ADDR_A11: rd_word = coef_q.a11;
			ADDR_A12: rd_word = coef_q.a12;
			ADDR_B10: rd_word = coef_q.b10;
			ADDR_B11: rd_word = coef_q.b11;
			ADDR_B12: rd_word = coef_q.b12;
			default:  rd_word = '0;
		endcase
	end

	// ack and read data
	// dat_o is loaded at the same edge that raises ack, so it is valid
	// for exactly the ack cycle and returns to zero afterwards
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			ack_q <= 1'b0;
			dat_o <= '0;
		end
		else
		begin
			ack_q <= req;
			if (rd_en)
			begin
				dat_o <= rd_word;
			end
			else
			begin
				dat_o <= '0;
			end
		end
	end

	// coefficient registers
	// only the addressed register is written
	// writes to unmapped addresses fall through the default and change nothing
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			coef_q <= '0;
		end
		else if (wr_en)
		begin
			case (adr_i)
				ADDR_A11: coef_q.a11 <= dat_i;
				ADDR_A12: coef_q.a12 <= dat_i;
				ADDR_B10: coef_q.b10 <= dat_i;
				ADDR_B11: coef_q.b11 <= dat_i;
				ADDR_B12: coef_q.b12 <= dat_i;
				default:  coef_q <= coef_q;
			endcase
		end
	end

	assign ack_o = ack_q;

	// the filter sees the registers directly
	// a write at edge k applies to the sample taken at edge k+1
	assign coefs_o = coef_q;

endmodule

// File: out_saturate.sv
`timescale 1ns/1ps

// clamps the wide y to DATA_W bits and registers it with a valid flag
module out_saturate
	import biquad_arith_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF
)
(
	input  logic                               clk,
	input  logic                               rst_i,
	input  logic signed [DATA_W+STATE_EXT-1:0] y_full_i,
	input  logic                               y_step_i,
	output logic signed [DATA_W-1:0]           y_o,
	output logic                               y_valid_o
);

	localparam int STATE_W = state_width(DATA_W);
	// output limits
	localparam logic signed [DATA_W-1:0] Y_MAX = {1'b0, {(DATA_W-1){1'b1}}};
	localparam logic signed [DATA_W-1:0] Y_MIN = {1'b1, {(DATA_W-1){1'b0}}};

	// y fits when the bits above the output msb all copy the sign
	logic fits;
	logic signed [DATA_W-1:0] y_sat;

	assign fits = (&y_full_i[STATE_W-1:DATA_W-1]) | ~(|y_full_i[STATE_W-1:DATA_W-1]);

	always_comb
	begin
		if (fits)
			y_sat = y_full_i[DATA_W-1:0];
		else if (y_full_i[STATE_W-1])
			y_sat = Y_MIN;
		else
			y_sat = Y_MAX;
	end

	// output holds between samples, valid is a one-cycle pulse
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			y_o <= '0;
			y_valid_o <= 1'b0;
		end
		else
		begin
			y_valid_o <= y_step_i;
			if (y_step_i)
				y_o <= y_sat;
		end
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the biquad testbench with verilator and run it
# the run passes only when the log holds the pass message
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module tb_biquad -f biquad.f -o tb_biquad \
	&& ./obj_dir/tb_biquad | tee sim.log \
	&& grep -q "All checks passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_biquad.sv
`timescale 1ns/1ps

// directed testbench for the biquad section
// a longint model of the filter arithmetic runs next to the DUT
module tb_biquad
	import biquad_arith_pkg::*;
	import coef_map_pkg::*;
();

	localparam int DATA_W = DATA_W_DEF;
	localparam int COEF_W = COEF_W_DEF;
	localparam int GUARD_W = GUARD_W_DEF;
	localparam int WORD_W = $bits(wb_word_t);
	// accumulator is the wide y plus guard fraction bits
	localparam int ACC_W = DATA_W + 4 + GUARD_W;
	localparam int P_SHIFT = COEF_W - 1 - GUARD_W;
	localparam longint Y_MAX = (64'sd1 <<< (DATA_W - 1)) - 1;
	localparam longint Y_MIN = -(64'sd1 <<< (DATA_W - 1));
	// cycles allowed for any single wait
	localparam int WAIT_LIMIT = 8;

	logic clk;
	logic rst_i;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	wb_addr_t adr_i;
	wb_word_t dat_i;
	logic ack_o;
	wb_word_t dat_o;
	logic signed [DATA_W-1:0] x_i;
	logic valid_i;
	logic signed [DATA_W-1:0] y_o;
	logic y_valid_o;

	int n_checks;
	int n_errors;

	// model state and the coefficient words indexed by bus address
	wb_word_t m_coef [8];
	longint m_s1;
	longint m_s2;
	// last expected output that y_o holds across gaps
	longint last_y;

	biquad_top uut (
		.clk       (clk),
		.rst_i     (rst_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.ack_o     (ack_o),
		.dat_o     (dat_o),
		.x_i       (x_i),
		.valid_i   (valid_i),
		.y_o       (y_o),
		.y_valid_o (y_valid_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic expect_true(input bit ok, input string msg);
		n_checks++;
		if (!ok)
			n_errors++;
		assert (ok) else $display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	// top COEF_W bits of a register word, signed
	function automatic longint coef_of(input wb_addr_t a);
		return longint'($signed(m_coef[a][WORD_W-1 -: COEF_W]));
	endfunction

	// keep the low ACC_W bits and sign extend them
	function automatic longint wrap_acc(input longint v);
		longint m;
		m = v & ((64'sd1 <<< ACC_W) - 1);
		if (m >= (64'sd1 <<< (ACC_W - 1)))
			m = m - (64'sd1 <<< ACC_W);
		return m;
	endfunction

	// full product floored to guard precision
	function automatic longint scaled(input longint v, input longint c);
		return wrap_acc((v * c) >>> P_SHIFT);
	endfunction

	function automatic longint clamp_out(input longint y);
		if (y > Y_MAX)
			return Y_MAX;
		if (y < Y_MIN)
			return Y_MIN;
		return y;
	endfunction

	// value in [-lim, lim-1]
	function automatic longint rand_range(input longint lim);
		longint r;
		r = longint'($urandom);
		return (r % (2 * lim)) - lim;
	endfunction

	// coefficient in the top bits and random junk in the ignored low bits
	function automatic wb_word_t coef_word(input longint c);
		longint low;
		low = longint'($urandom) & ((64'sd1 <<< (WORD_W - COEF_W)) - 1);
		return wb_word_t'((c <<< (WORD_W - COEF_W)) | low);
	endfunction

	function automatic wb_word_t pattern_word(input longint i);
		return wb_word_t'(i * 64'h3b1d + 64'h0417);
	endfunction

	// one sample of the transposed form
	task automatic model_step(input longint x, output longint y_exp);
		longint acc;
		longint y_wide;
		acc = wrap_acc(scaled(x, coef_of(ADDR_B10)) + m_s1);
		// dropping the guard bits floors and the result fits the state width
		y_wide = acc >>> GUARD_W;
		m_s1 = wrap_acc(scaled(x, coef_of(ADDR_B11)) + scaled(y_wide, coef_of(ADDR_A11))
			+ m_s2);
		m_s2 = wrap_acc(scaled(x, coef_of(ADDR_B12)) + scaled(y_wide, coef_of(ADDR_A12)));
		y_exp = clamp_out(y_wide);
	endtask

	task automatic apply_reset();
		valid_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		rst_i = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		rst_i = 1'b0;
		for (int i = 0; i < 8; i++)
			m_coef[wb_addr_t'(i)] = '0;
		m_s1 = 0;
		m_s2 = 0;
		last_y = 0;
	endtask

	// one classic cycle with ack one clock after the request
	task automatic bus_access(input bit write, input wb_addr_t a, input wb_word_t d,
		output wb_word_t rd);
		int waited;
		int idle;
		valid_i = 1'b0;
		// a new request only counts once the previous ack has dropped
		idle = 0;
		while (ack_o && idle < WAIT_LIMIT)
		begin
			@(posedge clk);
			#1;
			idle++;
		end
		if (ack_o)
		begin
			$display("timeout: ack_o stayed high for %0d cycles before address %0d", idle, a);
			n_errors++;
		end
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = write;
		adr_i = a;
		dat_i = d;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			waited++;
		end while (!ack_o && waited < WAIT_LIMIT);
		rd = dat_o;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		if (!ack_o)
		begin
			$display("timeout: no ack for address %0d after %0d cycles", a, waited);
			n_errors++;
		end
		else
			expect_true(waited == 1, $sformatf("ack came %0d cycles after request", waited));
		// unmapped addresses keep nothing
		if (write && a <= ADDR_B12)
			m_coef[a] = d;
	endtask

	task automatic write_reg(input wb_addr_t a, input wb_word_t d);
		wb_word_t unused_rd;
		bus_access(1'b1, a, d, unused_rd);
	endtask

	task automatic read_reg(input wb_addr_t a, output wb_word_t rd);
		bus_access(1'b0, a, '0, rd);
	endtask

	// drive one sample, wait for its output and compare with the model
	task automatic send_sample(input longint x, output longint got);
		longint exp_y;
		int waited;
		model_step(x, exp_y);
		x_i = DATA_W'(x);
		valid_i = 1'b1;
		waited = 0;
		do
		begin
			@(posedge clk);
			#1;
			valid_i = 1'b0;
			waited++;
		end while (!y_valid_o && waited < WAIT_LIMIT);
		got = longint'(y_o);
		last_y = exp_y;
		if (!y_valid_o)
		begin
			$display("timeout: no output valid after %0d cycles", waited);
			n_errors++;
		end
		else
		begin
			expect_true(waited == 1, $sformatf("output came %0d cycles after sample", waited));
			expect_true(got == exp_y, $sformatf("y_o is %0d, expected %0d", got, exp_y));
		end
	endtask

	// gap cycle where no output comes and y_o holds
	task automatic idle_cycle();
		valid_i = 1'b0;
		@(posedge clk);
		#1;
		expect_true(!y_valid_o, "y_valid_o high without a sample");
		expect_true(longint'(y_o) == last_y, $sformatf("y_o changed to %0d in a gap", y_o));
	endtask

	task automatic check_reset_state();
		int err0;
		wb_word_t rd;
		err0 = n_errors;
		apply_reset();
		expect_true(!y_valid_o, "y_valid_o high after reset");
		expect_true(!ack_o, "ack_o high after reset");
		expect_true(y_o == '0, $sformatf("y_o is %0d after reset", y_o));
		for (int i = 0; i < NUM_COEF; i++)
		begin
			read_reg(wb_addr_t'(i), rd);
			expect_true(rd == '0, $sformatf("address %0d reads %h after reset", i, rd));
		end
		$display("reset state: finished, %0d errors", n_errors - err0);
	endtask

	task automatic check_register_access();
		int err0;
		wb_word_t rd;
		err0 = n_errors;
		for (int i = 0; i < NUM_COEF; i++)
			write_reg(wb_addr_t'(i), pattern_word(i));
		for (int i = 0; i < NUM_COEF; i++)
		begin
			read_reg(wb_addr_t'(i), rd);
			expect_true(rd == pattern_word(i), $sformatf("address %0d reads %h", i, rd));
		end
		// unmapped space reads zero and touches no coefficient
		for (int i = NUM_COEF; i < 8; i++)
		begin
			write_reg(wb_addr_t'(i), 16'hffff);
			read_reg(wb_addr_t'(i), rd);
			expect_true(rd == '0, $sformatf("unmapped address %0d reads %h", i, rd));
		end
		for (int i = 0; i < NUM_COEF; i++)
		begin
			read_reg(wb_addr_t'(i), rd);
			expect_true(rd == pattern_word(i), $sformatf("address %0d now %h", i, rd));
		end
		$display("register access: finished, %0d errors", n_errors - err0);
	endtask

	task automatic run_fir_impulse();
		int err0;
		longint got;
		longint amp;
		longint exp_y;
		err0 = n_errors;
		apply_reset();
		write_reg(ADDR_A11, '0);
		write_reg(ADDR_A12, '0);
		write_reg(ADDR_B10, 16'h4009);
		write_reg(ADDR_B11, 16'hc00f);
		write_reg(ADDR_B12, 16'h2005);
		amp = Y_MAX;
		for (int k = 0; k < 5; k++)
		begin
			send_sample((k == 0) ? amp : 0, got);
			// the impulse response is each tap times amp floored once
			if (k < 3)
				exp_y = (amp * coef_of(wb_addr_t'(int'(ADDR_B10) + k))) >>> (COEF_W - 1);
			else
				exp_y = 0;
			expect_true(got == exp_y, $sformatf("tap %0d gives %0d, expected %0d", k, got, exp_y));
			idle_cycle();
		end
		$display("fir impulse: finished, %0d errors", n_errors - err0);
	endtask

	task automatic run_iir_stream();
		int err0;
		longint got;
		err0 = n_errors;
		apply_reset();
		// feedback sum stays under one half
		write_reg(ADDR_A11, coef_word(rand_range(256)));
		write_reg(ADDR_A12, coef_word(rand_range(256)));
		write_reg(ADDR_B10, coef_word(rand_range(512)));
		write_reg(ADDR_B11, coef_word(rand_range(512)));
		write_reg(ADDR_B12, coef_word(rand_range(512)));
		repeat (200) send_sample(rand_range(64'sd1 <<< (DATA_W - 1)), got);
		idle_cycle();
		$display("iir stream: finished, %0d errors", n_errors - err0);
	endtask

	task automatic run_saturation_gaps();
		int err0;
		int hit_max;
		int hit_min;
		longint got;
		longint x;
		err0 = n_errors;
		apply_reset();
		write_reg(ADDR_A11, 16'h1800);
		write_reg(ADDR_A12, '0);
		write_reg(ADDR_B10, 16'h7ff0);
		write_reg(ADDR_B11, 16'h7ff0);
		write_reg(ADDR_B12, 16'h7ff0);
		hit_max = 0;
		hit_min = 0;
		repeat (120)
		begin
			if ($urandom % 3 == 0)
				idle_cycle();
			else
			begin
				// mostly full scale and sometimes anything
				if ($urandom % 4 == 0)
					x = rand_range(64'sd1 <<< (DATA_W - 1));
				else
					x = ($urandom % 2 == 0) ? Y_MAX : Y_MIN;
				send_sample(x, got);
				if (got == Y_MAX)
					hit_max++;
				if (got == Y_MIN)
					hit_min++;
			end
		end
		expect_true(hit_max > 0 && hit_min > 0,
			$sformatf("clamps seen: %0d at max, %0d at min", hit_max, hit_min));
		$display("saturation and gaps: finished, %0d errors", n_errors - err0);
	endtask

	task automatic run_coef_change();
		int err0;
		longint got;
		wb_word_t rd;
		err0 = n_errors;
		apply_reset();
		write_reg(ADDR_A11, 16'h3000);
		write_reg(ADDR_A12, 16'hf000);
		write_reg(ADDR_B10, 16'h2000);
		write_reg(ADDR_B11, 16'h1000);
		write_reg(ADDR_B12, 16'h0800);
		repeat (20) send_sample(rand_range(1024), got);
		// new b10 applies from the next sample on
		write_reg(ADDR_B10, 16'hb000);
		repeat (20) send_sample(rand_range(1024), got);
		read_reg(ADDR_B10, rd);
		expect_true(rd == 16'hb000, $sformatf("b10 reads %h after rewrite", rd));
		$display("coefficient change: finished, %0d errors", n_errors - err0);
	endtask

	initial
	begin
		void'($urandom(32'hc02292bb));
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		x_i = '0;
		valid_i = 1'b0;
		n_checks = 0;
		n_errors = 0;
		check_reset_state();
		check_register_access();
		run_fir_impulse();
		run_iir_stream();
		run_saturation_gaps();
		run_coef_change();
		$display("%0d checks run, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// whole run limit
	initial
	begin
		#1000000;
		$display("simulation did not finish in time");
		$display("Checks failed");
		$finish;
	end

endmodule
